// File: hw/adc_cfg_pkg.sv
package adc_cfg_pkg;

	// Word and address widths.
	localparam int word_width = 16;
	localparam int addr_width = 4;

	// Sample-delay configuration group.
	localparam int sdc_base = 0;
	localparam int sdc_samples = 2;
	localparam int sdc_width = sdc_samples * word_width;

	// Buffer configuration, a single word.
	localparam int buffc_addr = 2;

	// Channel-mux configuration group.
	localparam int chan_base = 3;
	localparam int chan_samples = 4;
	localparam int chan_width = chan_samples * word_width;

	// Read-only timestamp words and capture count.
	localparam int ts_base = 8;
	localparam int ts_samples = 2;
	localparam int ts_width = ts_samples * word_width;
	localparam int ts_count_addr = 10;

	// Last word of each group, a write here marks the group fresh.
	localparam int sdc_commit_addr = sdc_base + sdc_samples - 1;
	localparam int buffc_commit_addr = buffc_addr;
	localparam int chan_commit_addr = chan_base + chan_samples - 1;

	// Register groups.
	typedef enum logic [1:0] {
		grp_sdc,
		grp_buffc,
		grp_chan
	} grp_t;

	// Dispatcher states.
	typedef enum logic [1:0] {
		idle,
		load_sdc,
		load_buffc,
		load_chan
	} disp_state_t;

endpackage

// File: hw/cfg_decode.sv
module cfg_decode import adc_cfg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic host_req,
	input logic host_we,
	input logic [addr_width-1:0] host_addr,
	input logic [word_width-1:0] host_wdata,
	output logic host_ack,
	output logic [word_width-1:0] host_rdata,
	input logic consume_valid,
	input grp_t consume_grp,
	input logic [ts_samples-1:0][word_width-1:0] ts_words,
	input logic [word_width-1:0] ts_count,
	output logic [sdc_samples-1:0][word_width-1:0] sdc_words,
	output logic [word_width-1:0] buffc_word,
	output logic [chan_samples-1:0][word_width-1:0] chan_words,
	output logic fresh_sdc,
	output logic fresh_buffc,
	output logic fresh_chan
);

	// Four-phase handshake with the host.
	typedef enum logic [1:0] {
		ph_idle,
		ph_access,
		ph_ack,
		ph_drop
	} phase_t;

	phase_t phase;
	logic access;
	logic wr_en;
	logic commit_sdc;
	logic commit_buffc;
	logic commit_chan;
	logic clr_sdc;
	logic clr_buffc;
	logic clr_chan;
	logic [word_width-1:0] rd_word;

	assign access = (phase == ph_access);
	assign wr_en = access && host_we;
	// Ack stays up until one cycle after req is seen low.
	assign host_ack = (phase == ph_ack) || (phase == ph_drop);

	assign commit_sdc = wr_en && (host_addr == addr_width'(sdc_commit_addr));
	assign commit_buffc = wr_en && (host_addr == addr_width'(buffc_commit_addr));
	assign commit_chan = wr_en && (host_addr == addr_width'(chan_commit_addr));

	assign clr_sdc = consume_valid && (consume_grp == grp_sdc);
	assign clr_buffc = consume_valid && (consume_grp == grp_buffc);
	assign clr_chan = consume_valid && (consume_grp == grp_chan);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= ph_idle;
		end else begin
			case (phase)
				ph_idle: begin
					if (host_req)
						phase <= ph_access;
				end
				ph_access: phase <= ph_ack;
				ph_ack: begin
					if (!host_req)
						phase <= ph_drop;
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// Writable register map.
	always_ff @(posedge clk) begin
		if (rst) begin
			sdc_words <= '0;
			buffc_word <= '0;
			chan_words <= '0;
		end else if (wr_en) begin
			for (int i = 0; i < sdc_samples; i++) begin
				if (host_addr == addr_width'(sdc_base + i))
					sdc_words[i] <= host_wdata;
			end
			if (host_addr == addr_width'(buffc_addr))
				buffc_word <= host_wdata;
			for (int i = 0; i < chan_samples; i++) begin
				if (host_addr == addr_width'(chan_base + i))
					chan_words[i] <= host_wdata;
			end
		end
	end

	// A commit in the same cycle as a consume keeps the flag set.
	always_ff @(posedge clk) begin
		if (rst) begin
			fresh_sdc <= 1'b0;
			fresh_buffc <= 1'b0;
			fresh_chan <= 1'b0;
		end else begin
			fresh_sdc <= commit_sdc || (fresh_sdc && !clr_sdc);
			fresh_buffc <= commit_buffc || (fresh_buffc && !clr_buffc);
			fresh_chan <= commit_chan || (fresh_chan && !clr_chan);
		end
	end

	// Read-back mux, unmapped addresses give zero.
	always_comb begin
		rd_word = '0;
		for (int i = 0; i < sdc_samples; i++) begin
			if (host_addr == addr_width'(sdc_base + i))
				rd_word = sdc_words[i];
		end
		if (host_addr == addr_width'(buffc_addr))
			rd_word = buffc_word;
		for (int i = 0; i < chan_samples; i++) begin
			if (host_addr == addr_width'(chan_base + i))
				rd_word = chan_words[i];
		end
		for (int i = 0; i < ts_samples; i++) begin
			if (host_addr == addr_width'(ts_base + i))
				rd_word = ts_words[i];
		end
		if (host_addr == addr_width'(ts_count_addr))
			rd_word = ts_count;
	end

	always_ff @(posedge clk) begin
		if (rst)
			host_rdata <= '0;
		else if (access && !host_we)
			host_rdata <= rd_word;
	end

endmodule

// File: hw/cfg_dispatch.sv
module cfg_dispatch import adc_cfg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [sdc_samples-1:0][word_width-1:0] sdc_words,
	input logic [word_width-1:0] buffc_word,
	input logic [chan_samples-1:0][word_width-1:0] chan_words,
	input logic fresh_sdc,
	input logic fresh_buffc,
	input logic fresh_chan,
	output logic consume_valid,
	output grp_t consume_grp,
	input logic sdc_ready,
	input logic buffc_ready,
	input logic cmc_ready,
	output logic sdc_valid,
	output logic [sdc_width-1:0] sdc_data,
	output logic sdc_last,
	output logic buffc_valid,
	output logic [word_width-1:0] buffc_data,
	output logic buffc_last,
	output logic cmc_valid,
	output logic [chan_width-1:0] cmc_data,
	output logic cmc_last
);

	disp_state_t state;
	logic [sdc_width-1:0] sdc_hold;
	logic [word_width-1:0] buffc_hold;
	logic [chan_width-1:0] cmc_hold;
	logic pick_sdc;
	logic pick_buffc;
	logic pick_chan;

	// A group is eligible only when its stream holds no beat.
	assign pick_sdc = fresh_sdc && !sdc_valid;
	assign pick_buffc = fresh_buffc && !buffc_valid;
	assign pick_chan = fresh_chan && !cmc_valid;

	// Consume is taken on the same edge as the snapshot.
	always_comb begin
		consume_valid = (state != idle);
		case (state)
			load_buffc: consume_grp = grp_buffc;
			load_chan: consume_grp = grp_chan;
			default: consume_grp = grp_sdc;
		endcase
	end

	// Priority is SDC, then buffer, then channel mux.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (pick_sdc)
						state <= load_sdc;
					else if (pick_buffc)
						state <= load_buffc;
					else if (pick_chan)
						state <= load_chan;
				end
				default: state <= idle;
			endcase
		end
	end

	// Snapshot of the register words.
	always_ff @(posedge clk) begin
		if (state == load_sdc)
			sdc_hold <= sdc_words;
		if (state == load_buffc)
			buffc_hold <= buffc_word;
		if (state == load_chan)
			cmc_hold <= chan_words;
	end

	// Each stream holds its beat until accepted.
	always_ff @(posedge clk) begin
		if (rst) begin
			sdc_valid <= 1'b0;
			buffc_valid <= 1'b0;
			cmc_valid <= 1'b0;
		end else begin
			if (state == load_sdc)
				sdc_valid <= 1'b1;
			else if (sdc_ready)
				sdc_valid <= 1'b0;
			if (state == load_buffc)
				buffc_valid <= 1'b1;
			else if (buffc_ready)
				buffc_valid <= 1'b0;
			if (state == load_chan)
				cmc_valid <= 1'b1;
			else if (cmc_ready)
				cmc_valid <= 1'b0;
		end
	end

	// Single-beat packets.
	assign sdc_last = sdc_valid;
	assign buffc_last = buffc_valid;
	assign cmc_last = cmc_valid;

	assign sdc_data = sdc_valid ? sdc_hold : '0;
	assign buffc_data = buffc_valid ? buffc_hold : '0;
	assign cmc_data = cmc_valid ? cmc_hold : '0;

endmodule

// File: hw/ts_capture.sv
module ts_capture import adc_cfg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic bufft_valid,
	input logic [ts_width-1:0] bufft_data,
	output logic bufft_ready,
	output logic [ts_samples-1:0][word_width-1:0] ts_words,
	output logic [word_width-1:0] ts_count
);

	logic take;

	// Never stalls once out of reset.
	assign take = bufft_valid && bufft_ready;

	always_ff @(posedge clk) begin
		if (rst)
			bufft_ready <= 1'b0;
		else
			bufft_ready <= 1'b1;
	end

	// Latest timestamp pair, word 0 in the low half.
	always_ff @(posedge clk) begin
		if (rst)
			ts_words <= '0;
		else if (take)
			ts_words <= bufft_data;
	end

	// Wraps at the word width.
	always_ff @(posedge clk) begin
		if (rst)
			ts_count <= '0;
		else if (take)
			ts_count <= ts_count + 1'b1;
	end

endmodule

// File: hw/adc_cfg_top.sv
module adc_cfg_top import adc_cfg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic host_req,
	input logic host_we,
	input logic [addr_width-1:0] host_addr,
	input logic [word_width-1:0] host_wdata,
	output logic host_ack,
	output logic [word_width-1:0] host_rdata,
	output logic sdc_valid,
	input logic sdc_ready,
	output logic [sdc_width-1:0] sdc_data,
	output logic sdc_last,
	output logic buffc_valid,
	input logic buffc_ready,
	output logic [word_width-1:0] buffc_data,
	output logic buffc_last,
	output logic cmc_valid,
	input logic cmc_ready,
	output logic [chan_width-1:0] cmc_data,
	output logic cmc_last,
	input logic bufft_valid,
	input logic [ts_width-1:0] bufft_data,
	output logic bufft_ready
);

	logic [sdc_samples-1:0][word_width-1:0] sdc_words;
	logic [word_width-1:0] buffc_word;
	logic [chan_samples-1:0][word_width-1:0] chan_words;
	logic fresh_sdc;
	logic fresh_buffc;
	logic fresh_chan;
	logic consume_valid;
	grp_t consume_grp;
	logic [ts_samples-1:0][word_width-1:0] ts_words;
	logic [word_width-1:0] ts_count;

	// Register map and host port.
	cfg_decode i_cfg_decode (
		.clk(clk),
		.rst(rst),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.consume_valid(consume_valid),
		.consume_grp(consume_grp),
		.ts_words(ts_words),
		.ts_count(ts_count),
		.sdc_words(sdc_words),
		.buffc_word(buffc_word),
		.chan_words(chan_words),
		.fresh_sdc(fresh_sdc),
		.fresh_buffc(fresh_buffc),
		.fresh_chan(fresh_chan)
	);

	// Output streams.
	cfg_dispatch i_cfg_dispatch (
		.clk(clk),
		.rst(rst),
		.sdc_words(sdc_words),
		.buffc_word(buffc_word),
		.chan_words(chan_words),
		.fresh_sdc(fresh_sdc),
		.fresh_buffc(fresh_buffc),
		.fresh_chan(fresh_chan),
		.consume_valid(consume_valid),
		.consume_grp(consume_grp),
		.sdc_ready(sdc_ready),
		.buffc_ready(buffc_ready),
		.cmc_ready(cmc_ready),
		.sdc_valid(sdc_valid),
		.sdc_data(sdc_data),
		.sdc_last(sdc_last),
		.buffc_valid(buffc_valid),
		.buffc_data(buffc_data),
		.buffc_last(buffc_last),
		.cmc_valid(cmc_valid),
		.cmc_data(cmc_data),
		.cmc_last(cmc_last)
	);

	// Timestamp read-back.
	ts_capture i_ts_capture (
		.clk(clk),
		.rst(rst),
		.bufft_valid(bufft_valid),
		.bufft_data(bufft_data),
		.bufft_ready(bufft_ready),
		.ts_words(ts_words),
		.ts_count(ts_count)
	);

endmodule

// File: tests/adc_cfg_checker.sv
module adc_cfg_checker import adc_cfg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic host_req,
	input logic host_ack,
	input logic consume_valid,
	input logic sdc_valid,
	input logic sdc_ready,
	input logic [sdc_width-1:0] sdc_data,
	input logic sdc_last,
	input logic buffc_valid,
	input logic buffc_ready,
	input logic [word_width-1:0] buffc_data,
	input logic buffc_last,
	input logic cmc_valid,
	input logic cmc_ready,
	input logic [chan_width-1:0] cmc_data,
	input logic cmc_last
);
	timeunit 1ns;
	timeprecision 1ps;

	// A held beat keeps valid and data until it is taken.
	sdc_hold_a: assert property (@(posedge clk) disable iff (rst)
		sdc_valid && !sdc_ready |=> sdc_valid && $stable(sdc_data))
		else $error("sdc beat dropped or changed before ready");
	buffc_hold_a: assert property (@(posedge clk) disable iff (rst)
		buffc_valid && !buffc_ready |=> buffc_valid && $stable(buffc_data))
		else $error("buffc beat dropped or changed before ready");
	cmc_hold_a: assert property (@(posedge clk) disable iff (rst)
		cmc_valid && !cmc_ready |=> cmc_valid && $stable(cmc_data))
		else $error("cmc beat dropped or changed before ready");

	// Single-beat packets.
	last_a: assert property (@(posedge clk) disable iff (rst)
		(sdc_last == sdc_valid) && (buffc_last == buffc_valid) && (cmc_last == cmc_valid))
		else $error("last differs from valid");

	ack_a: assert property (@(posedge clk) disable iff (rst)
		$rose(host_ack) |-> host_req)
		else $error("host_ack rose without host_req");

	consume_a: assert property (@(posedge clk) disable iff (rst)
		consume_valid |=> !consume_valid)
		else $error("consume held longer than one cycle");

endmodule

bind cfg_dispatch adc_cfg_checker i_dispatch_checker (
	.clk(clk),
	.rst(rst),
	.host_req(1'b0),
	.host_ack(1'b0),
	.consume_valid(consume_valid),
	.sdc_valid(sdc_valid),
	.sdc_ready(sdc_ready),
	.sdc_data(sdc_data),
	.sdc_last(sdc_last),
	.buffc_valid(buffc_valid),
	.buffc_ready(buffc_ready),
	.buffc_data(buffc_data),
	.buffc_last(buffc_last),
	.cmc_valid(cmc_valid),
	.cmc_ready(cmc_ready),
	.cmc_data(cmc_data),
	.cmc_last(cmc_last)
);

// The decode side has no streams to check.
bind cfg_decode adc_cfg_checker i_decode_checker (
	.clk(clk),
	.rst(rst),
	.host_req(host_req),
	.host_ack(host_ack),
	.consume_valid(consume_valid),
	.sdc_valid(1'b0),
	.sdc_ready(1'b0),
	.sdc_data('0),
	.sdc_last(1'b0),
	.buffc_valid(1'b0),
	.buffc_ready(1'b0),
	.buffc_data('0),
	.buffc_last(1'b0),
	.cmc_valid(1'b0),
	.cmc_ready(1'b0),
	.cmc_data('0),
	.cmc_last(1'b0)
);

// File: tests/tb_adc_cfg.sv
module tb_adc_cfg import adc_cfg_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeout_cycles = 200;

	logic clk;
	logic rst;
	logic host_req;
	logic host_we;
	logic [addr_width-1:0] host_addr;
	logic [word_width-1:0] host_wdata;
	logic host_ack;
	logic [word_width-1:0] host_rdata;
	logic sdc_valid;
	logic sdc_ready;
	logic [sdc_width-1:0] sdc_data;
	logic sdc_last;
	logic buffc_valid;
	logic buffc_ready;
	logic [word_width-1:0] buffc_data;
	logic buffc_last;
	logic cmc_valid;
	logic cmc_ready;
	logic [chan_width-1:0] cmc_data;
	logic cmc_last;
	logic bufft_valid;
	logic [ts_width-1:0] bufft_data;
	logic bufft_ready;

	// Ready mode per stream is 0 for always, 1 for never and 2 for random.
	logic [1:0] ready_mode [0:2];
	logic [63:0] sdc_q [$];
	logic [63:0] buffc_q [$];
	logic [63:0] cmc_q [$];
	integer seed;
	integer fd;

	adc_cfg_top i_adc_cfg_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic ready_value(input logic [1:0] mode);
		logic [31:0] r;
		case (mode)
			2'd0: return 1'b1;
			2'd1: return 1'b0;
			default: begin
				r = $random(seed);
				return r[0];
			end
		endcase
	endfunction

	initial begin
		sdc_ready = 1'b0;
		buffc_ready = 1'b0;
		cmc_ready = 1'b0;
		forever begin
			@(posedge clk);
			sdc_ready <= ready_value(ready_mode[0]);
			buffc_ready <= ready_value(ready_mode[1]);
			cmc_ready <= ready_value(ready_mode[2]);
		end
	end

	// Every accepted beat is a whole packet and goes into its stream's queue.
	always @(posedge clk) begin
		if (!rst) begin
			if (sdc_valid && sdc_ready) begin
				check_value("sdc_last", 64'h1, 64'(sdc_last));
				sdc_q.push_back(64'(sdc_data));
			end
			if (buffc_valid && buffc_ready) begin
				check_value("buffc_last", 64'h1, 64'(buffc_last));
				buffc_q.push_back(64'(buffc_data));
			end
			if (cmc_valid && cmc_ready) begin
				check_value("cmc_last", 64'h1, 64'(cmc_last));
				cmc_q.push_back(cmc_data);
			end
		end
	end

	function automatic string stream_name(input int stream);
		case (stream)
			0: return "sdc";
			1: return "buffc";
			default: return "cmc";
		endcase
	endfunction

	function automatic int queue_size(input int stream);
		case (stream)
			0: return sdc_q.size();
			1: return buffc_q.size();
			default: return cmc_q.size();
		endcase
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual == expected) else begin
			stop_run($sformatf("FAILED %s: expected %0h, got %0h", name, expected, actual));
		end
	endtask

	// Four-phase access that drops req once ack is seen.
	task automatic host_access(input logic we, input logic [addr_width-1:0] addr,
		input logic [word_width-1:0] wdata, output logic [word_width-1:0] rdata);
		int waited;
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= we;
		host_addr <= addr;
		host_wdata <= wdata;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			assert (waited < timeout_cycles) else stop_run("No host_ack after host_req rose");
		end while (!host_ack);
		rdata = host_rdata;
		host_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			assert (waited < timeout_cycles) else stop_run("host_ack stayed high after req fell");
		end while (host_ack);
	endtask

	task automatic push_timestamp(input logic [word_width-1:0] w0,
		input logic [word_width-1:0] w1);
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			assert (waited < timeout_cycles) else stop_run("bufft_ready never went high");
		end while (!bufft_ready);
		bufft_valid <= 1'b1;
		bufft_data <= {w1, w0};
		@(posedge clk);
		bufft_valid <= 1'b0;
	endtask

	task automatic expect_beat(input int stream, input logic [63:0] expected);
		int waited;
		logic [63:0] beat;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			assert (waited < timeout_cycles) else
				stop_run($sformatf("No beat arrived on the %s stream", stream_name(stream)));
		end while (queue_size(stream) == 0);
		case (stream)
			0: beat = sdc_q.pop_front();
			1: beat = buffc_q.pop_front();
			default: beat = cmc_q.pop_front();
		endcase
		check_value({stream_name(stream), "_data"}, expected, beat);
	endtask

	task automatic run_command(input logic [7:0] cmd, input logic [63:0] a, input logic [63:0] b);
		logic [word_width-1:0] rd;
		case (cmd)
			"w": host_access(1'b1, a[addr_width-1:0], b[word_width-1:0], rd);
			"r": begin
				host_access(1'b0, a[addr_width-1:0], '0, rd);
				check_value("host_rdata", b, {48'h0, rd});
			end
			"m": begin
				@(negedge clk);
				ready_mode[a[1:0]] = b[1:0];
			end
			"t": push_timestamp(a[word_width-1:0], b[word_width-1:0]);
			"e": expect_beat(int'(a), b);
			"n": begin
				@(negedge clk);
				check_value({stream_name(int'(a)), " beat count"}, 64'h0,
					64'(queue_size(int'(a))));
			end
			"i": repeat (int'(a)) @(posedge clk);
			default: stop_run($sformatf("Unknown command %c in the golden file", cmd));
		endcase
	endtask

	initial begin
		string line;
		logic [7:0] cmd;
		logic [63:0] arg_a;
		logic [63:0] arg_b;
		int fields;
		int commands;
		seed = 32'h496c_81b8;
		commands = 0;
		rst = 1'b1;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		bufft_valid = 1'b0;
		bufft_data = '0;
		for (int i = 0; i < 3; i++)
			ready_mode[i] = 2'd0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("tests/adc_cfg_golden.txt", "r");
		assert (fd != 0) else stop_run("Could not open tests/adc_cfg_golden.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#") begin
				arg_a = '0;
				arg_b = '0;
				fields = $sscanf(line, "%c %h %h", cmd, arg_a, arg_b);
				if (fields >= 2) begin
					run_command(cmd, arg_a, arg_b);
					commands++;
				end
			end
		end
		$fclose(fd);
		repeat (4) @(posedge clk);
		if (commands > 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_run("The golden file held no commands");
		end
	end

endmodule

// File: tests/adc_cfg_golden.txt
# Columns are cmd, arg_a, arg_b in hex. w addr data, r addr expect, m stream mode,
# t word0 word1, e stream beat, n stream, i cycles. Streams 0 sdc, 1 buffc, 2 cmc.
w 0 1111
w 1 2222
w 2 3333
w 3 4444
w 4 5555
w 5 6666
w 6 7777
r 0 1111
r 1 2222
r 2 3333
r 3 4444
r 4 5555
r 5 6666
r 6 7777
e 0 22221111
e 1 3333
e 2 7777666655554444
w 8 dead
w a 1234
w 7 abcd
r 8 0
r a 0
r 7 0
r f 0
# Partial groups give no beat until the commit word.
w 3 a003
w 4 a004
w 5 a005
i 8
n 2
w 6 a006
e 2 a006a005a004a003
# Held sdc beat, two later commits coalesce, buffc passes meanwhile.
m 0 1
w 0 c000
w 1 c001
w 0 c100
w 1 c101
w 0 c200
w 1 c201
i 6
n 0
w 2 d002
e 1 d002
m 0 0
e 0 c001c000
e 0 c201c200
i a
n 0
# All groups back to back with random ready.
m 0 2
m 1 2
m 2 2
w 0 e000
w 3 e003
w 4 e004
w 5 e005
w 1 e001
w 2 e002
w 6 e006
e 0 e001e000
e 1 e002
e 2 e006e005e004e003
i 14
n 0
n 1
n 2
# Timestamp capture and count.
t 1111 2222
t 3333 4444
t 5555 6666
r 8 5555
r 9 6666
r a 3

// File: adc_cfg_top.f
hw/adc_cfg_pkg.sv
hw/cfg_decode.sv
hw/cfg_dispatch.sv
hw/ts_capture.sv
hw/adc_cfg_top.sv
tests/adc_cfg_checker.sv
tests/tb_adc_cfg.sv

// File: Makefile
.PHONY: all lint clean

all: obj_dir/Vtb_adc_cfg
	./obj_dir/Vtb_adc_cfg > sim.log 2>&1 || true
	cat sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

obj_dir/Vtb_adc_cfg: adc_cfg_top.f hw/*.sv tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_adc_cfg -f adc_cfg_top.f

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module tb_adc_cfg -f adc_cfg_top.f

clean:
	rm -rf obj_dir sim.log
